// File: files.f
+incdir+include
verilog/rf_pkg.sv
verilog/gpr_bank.sv
verilog/psr_bank.sv
verilog/bank_view.sv
verilog/arm_regfile.sv
sim/rf_checker.sv
sim/tb_arm_regfile.sv

// File: include/rf_defs.svh
// widths and counts for the banked register file
// the layout of the physical index space is fixed by rf_pkg::bank_index
`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// data word and PSR width
`define RF_DATA_W 32

// logical register address, r0..r15
`define RF_ADDR_W 4

// flags word as seen on the PSR write port
`define RF_FLAGS_W 11

// user r0-r15, fiq r8-r14, then r13/r14 for irq, svc, abt, und
`define RF_PHYS_REGS 31

// r15 is never banked
`define RF_PC_ADDR 15

`endif

// File: run_sim.sh
#!/bin/sh
# builds and runs the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
TOP=tb_arm_regfile

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi

echo "pass message not found in $LOG"
exit 1

// File: sim/rf_checker.sv
// shadow model of the banked register file checked at every falling edge
// model follows the DUT inputs at the rising edge, as the DUT does
`include "rf_defs.svh"

module rf_checker
(
	input logic sysclk,
	input logic arst_n,
	input rf_pkg::reg_write_t wr,
	input logic [`RF_DATA_W-1:0] pc_write,
	input rf_pkg::psr_write_t psr_wr,
	input rf_pkg::psr_sel_e psr_rd_sel,
	input rf_pkg::read_addr_t rd_addr,
	input rf_pkg::read_data_t rd_data,
	input logic [`RF_DATA_W-1:0] pc_read,
	input logic [`RF_DATA_W-1:0] psr_read,
	input int test_num,
	input logic test_done,
	output int check_count,
	output int error_count
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed
	{
		rf_pkg::read_data_t rd;
		logic [`RF_DATA_W-1:0] pc;
		logic [`RF_DATA_W-1:0] psr;
	} expect_t;

	logic [`RF_DATA_W-1:0] m_regs [`RF_PHYS_REGS];
	logic [`RF_DATA_W-1:0] m_cpsr;
	logic [`RF_DATA_W-1:0] m_spsr [5];
	int total_checks = 0;
	int total_errors = 0;
	int test_checks = 0;
	int test_errors = 0;

	assign check_count = total_checks;
	assign error_count = total_errors;

	// r8-r14 banked in fiq and only r13/r14 in the other privileged modes
	function automatic int phys_of(logic [4:0] m, logic [3:0] a);
		int idx;
		idx = int'(a);
		if (m == rf_pkg::MODE_FIQ && a >= 4'd8 && a <= 4'd14)
			idx = idx + 8;
		else if (a == 4'd13 || a == 4'd14)
		begin
			case (m)
			rf_pkg::MODE_IRQ: idx = idx + 10;
			rf_pkg::MODE_SVC: idx = idx + 12;
			rf_pkg::MODE_ABT: idx = idx + 14;
			rf_pkg::MODE_UND: idx = idx + 16;
			default: idx = idx;
			endcase
		end
		return idx;
	endfunction

	function automatic int spsr_of(logic [4:0] m);
		case (m)
		rf_pkg::MODE_FIQ: return 0;
		rf_pkg::MODE_IRQ: return 1;
		rf_pkg::MODE_SVC: return 2;
		rf_pkg::MODE_ABT: return 3;
		default: return 4;
		endcase
	endfunction

	function automatic logic legal_mode(logic [4:0] m);
		return m == 5'h10 || m == 5'h11 || m == 5'h12 || m == 5'h13 || m == 5'h17 || m == 5'h1b;
	endfunction

	// nzcv to 31..28, i/f to 7..6, mode to 4..0
	function automatic logic [`RF_DATA_W-1:0] packed_psr(logic [`RF_FLAGS_W-1:0] f);
		logic [`RF_DATA_W-1:0] w;
		w = '0;
		w[31:28] = f[10:7];
		w[7:6] = f[6:5];
		w[4:0] = f[4:0];
		return w;
	endfunction

	function automatic expect_t expected_outputs(rf_pkg::read_addr_t ra, rf_pkg::psr_sel_e sel);
		expect_t e;
		logic [4:0] cur;
		cur = m_cpsr[4:0];
		e.rd.a = m_regs[phys_of(cur, ra.a)];
		e.rd.b = m_regs[phys_of(cur, ra.b)];
		e.rd.c = m_regs[phys_of(cur, ra.c)];
		e.pc = m_regs[`RF_PC_ADDR];
		if (sel == rf_pkg::PSR_CPSR)
			e.psr = m_cpsr;
		else if (cur == rf_pkg::MODE_USR)
			e.psr = '0;
		else
			e.psr = m_spsr[spsr_of(cur)];
		return e;
	endfunction

	task automatic compare_word(input string port, input logic [31:0] expected,
		input logic [31:0] actual);
		total_checks++;
		test_checks++;
		if (actual !== expected)
		begin
			total_errors++;
			test_errors++;
			$display("[FAIL] %t %s expected %h actual %h", $realtime, port, expected, actual);
		end
	endtask

	always @(posedge sysclk or negedge arst_n)
	begin
		logic [4:0] cur;
		logic [4:0] nxt;
		int w_idx;
		if (!arst_n)
		begin
			for (int i = 0; i < `RF_PHYS_REGS; i++)
				m_regs[i] <= '0;
			for (int i = 0; i < 5; i++)
				m_spsr[i] <= '0;
			m_cpsr <= 32'h0000_0013;
		end
		else
		begin
			cur = m_cpsr[4:0];
			nxt = psr_wr.flags[4:0];
			w_idx = phys_of(cur, wr.addr);
			// bus write of r15 beats the pc path
			if (!(wr.load && w_idx == `RF_PC_ADDR))
				m_regs[`RF_PC_ADDR] <= pc_write;
			if (wr.load)
				m_regs[w_idx] <= wr.data;
			if (psr_wr.load && psr_wr.sel == rf_pkg::PSR_CPSR && legal_mode(nxt))
			begin
				m_cpsr <= packed_psr(psr_wr.flags);
				if (cur == rf_pkg::MODE_USR && nxt != rf_pkg::MODE_USR)
					m_spsr[spsr_of(nxt)] <= m_cpsr;
			end
			if (psr_wr.load && psr_wr.sel == rf_pkg::PSR_SPSR && cur != rf_pkg::MODE_USR)
				m_spsr[spsr_of(cur)] <= packed_psr(psr_wr.flags);
		end
	end

	always @(negedge sysclk)
	begin
		expect_t exp_v;
		if (arst_n)
		begin
			exp_v = expected_outputs(rd_addr, psr_rd_sel);
			compare_word("rd_data.a", exp_v.rd.a, rd_data.a);
			compare_word("rd_data.b", exp_v.rd.b, rd_data.b);
			compare_word("rd_data.c", exp_v.rd.c, rd_data.c);
			compare_word("pc_read", exp_v.pc, pc_read);
			compare_word("psr_read", exp_v.psr, psr_read);
			if (test_done)
			begin
				$display("test %0d finished: %0d checks, %0d errors", test_num, test_checks,
					test_errors);
				test_checks = 0;
				test_errors = 0;
			end
		end
	end

endmodule

// File: sim/tb_arm_regfile.sv
// directed and random tests of the banked register file
// inputs change 2 ns after the rising edge
// the checker compares at the falling edge
`include "rf_defs.svh"

module tb_arm_regfile;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;
	localparam int RANDOM_CYCLES = 400;
	localparam logic [31:0] SEED = 32'h9ebf_658b;

	logic sysclk;
	logic arst_n;
	rf_pkg::reg_write_t wr;
	logic [`RF_DATA_W-1:0] pc_write;
	rf_pkg::psr_write_t psr_wr;
	rf_pkg::psr_sel_e psr_rd_sel;
	rf_pkg::read_addr_t rd_addr;
	rf_pkg::read_data_t rd_data;
	logic [`RF_DATA_W-1:0] pc_read;
	logic [`RF_DATA_W-1:0] psr_read;

	int test_num;
	logic test_done;
	int tests_run;
	int check_count;
	int error_count;
	logic pc_random;
	logic clk_lost;
	time last_edge = 0;

	arm_regfile i_dut
	(
		.sysclk (sysclk),
		.arst_n (arst_n),
		.wr (wr),
		.pc_write (pc_write),
		.psr_wr (psr_wr),
		.psr_rd_sel (psr_rd_sel),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.pc_read (pc_read),
		.psr_read (psr_read)
	);

	rf_checker i_checker
	(
		.sysclk (sysclk),
		.arst_n (arst_n),
		.wr (wr),
		.pc_write (pc_write),
		.psr_wr (psr_wr),
		.psr_rd_sel (psr_rd_sel),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.pc_read (pc_read),
		.psr_read (psr_read),
		.test_num (test_num),
		.test_done (test_done),
		.check_count (check_count),
		.error_count (error_count)
	);

	initial
	begin
		sysclk = 1'b0;
		forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
	end

	always @(posedge sysclk)
		last_edge = $time;

	// flags a stopped clock so that no wait below can hang
	initial
	begin
		clk_lost = 1'b0;
		while (!clk_lost)
		begin
			#(CLK_PERIOD * 2);
			if ($time - last_edge > CLK_PERIOD * 2)
			begin
				clk_lost = 1'b1;
				$display("test %0d did not finish: no clock edge for %0d ns", test_num,
					CLK_PERIOD * 2);
			end
		end
	end

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n && !clk_lost; i++)
			@(posedge sysclk or posedge clk_lost);
	endtask

	task automatic advance();
		wait_cycles(1);
		#(DRIVE_DELAY);
		if (pc_random)
			pc_write = $urandom();
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		wr.load = 1'b1;
		wr.addr = addr;
		wr.data = data;
		advance();
		wr.load = 1'b0;
	endtask

	task automatic write_psr(input rf_pkg::psr_sel_e sel, input logic [`RF_FLAGS_W-1:0] flags);
		psr_wr.load = 1'b1;
		psr_wr.sel = sel;
		psr_wr.flags = flags;
		advance();
		psr_wr.load = 1'b0;
	endtask

	task automatic read_regs(input logic [3:0] a, input logic [3:0] b, input logic [3:0] c,
		input rf_pkg::psr_sel_e sel);
		rd_addr.a = a;
		rd_addr.b = b;
		rd_addr.c = c;
		psr_rd_sel = sel;
		advance();
	endtask

	// random condition and interrupt bits on top of the mode field
	task automatic enter_mode(input logic [4:0] m);
		write_psr(rf_pkg::PSR_CPSR, {6'($urandom_range(0, 63)), m});
	endtask

	function automatic logic [4:0] priv_mode(int i);
		case (i)
		0: return rf_pkg::MODE_FIQ;
		1: return rf_pkg::MODE_IRQ;
		2: return rf_pkg::MODE_SVC;
		3: return rf_pkg::MODE_ABT;
		4: return rf_pkg::MODE_UND;
		default: return rf_pkg::MODE_USR;
		endcase
	endfunction

	task automatic begin_test(input int n);
		test_num = n;
	endtask

	task automatic end_test();
		test_done = 1'b1;
		advance();
		test_done = 1'b0;
		tests_run++;
	endtask

	initial
	begin
		$timeformat(-9, 1, " ns", 10);
		void'($urandom(SEED));
		arst_n = 1'b0;
		wr = '0;
		pc_write = '0;
		psr_wr = '0;
		psr_rd_sel = rf_pkg::PSR_CPSR;
		rd_addr = '0;
		test_num = 0;
		test_done = 1'b0;
		tests_run = 0;
		pc_random = 1'b0;
		wait_cycles(4);
		#(DRIVE_DELAY);
		arst_n = 1'b1;

		// reset state with pc_write held at zero
		begin_test(1);
		read_regs(4'd0, 4'd7, 4'd15, rf_pkg::PSR_CPSR);
		read_regs(4'd13, 4'd14, 4'd8, rf_pkg::PSR_SPSR);
		end_test();

		begin_test(2);
		enter_mode(rf_pkg::MODE_USR);
		pc_random = 1'b1;
		for (int r = 0; r < 15; r++)
			write_reg(4'(r), $urandom());
		for (int i = 0; i < 16; i++)
			read_regs(4'(i), 4'(14 - i), 4'(i * 5), rf_pkg::PSR_CPSR);
		write_reg(4'd15, $urandom());
		read_regs(4'd15, 4'd0, 4'd15, rf_pkg::PSR_CPSR);
		read_regs(4'd15, 4'd15, 4'd1, rf_pkg::PSR_CPSR);
		end_test();

		begin_test(3);
		for (int m = 0; m < 5; m++)
		begin
			enter_mode(priv_mode(m));
			if (m == 0)
				for (int r = 8; r < 13; r++)
					write_reg(4'(r), $urandom());
			write_reg(4'd13, $urandom());
			write_reg(4'd14, $urandom());
		end
		enter_mode(rf_pkg::MODE_USR);
		for (int r = 8; r < 15; r++)
			read_regs(4'(r), 4'd15, 4'd0, rf_pkg::PSR_CPSR);
		for (int m = 0; m < 5; m++)
		begin
			enter_mode(priv_mode(m));
			read_regs(4'd8, 4'd9, 4'd10, rf_pkg::PSR_CPSR);
			read_regs(4'd11, 4'd12, 4'd13, rf_pkg::PSR_SPSR);
			read_regs(4'd14, 4'd13, 4'd15, rf_pkg::PSR_CPSR);
		end
		end_test();

		begin_test(4);
		for (int k = 0; k < 4; k++)
		begin
			enter_mode(rf_pkg::MODE_SVC);
			read_regs(4'd0, 4'd1, 4'd2, rf_pkg::PSR_CPSR);
		end
		for (int m = 1; m < 5; m += 2)
		begin
			enter_mode(priv_mode(m));
			write_psr(rf_pkg::PSR_SPSR, 11'($urandom_range(0, 2047)));
			read_regs(4'd13, 4'd14, 4'd15, rf_pkg::PSR_SPSR);
		end
		enter_mode(rf_pkg::MODE_UND);
		write_psr(rf_pkg::PSR_SPSR, 11'($urandom_range(0, 2047)));
		read_regs(4'd13, 4'd14, 4'd15, rf_pkg::PSR_SPSR);
		enter_mode(rf_pkg::MODE_USR);
		read_regs(4'd0, 4'd13, 4'd14, rf_pkg::PSR_SPSR);
		write_psr(rf_pkg::PSR_SPSR, 11'($urandom_range(0, 2047)));
		read_regs(4'd0, 4'd13, 4'd14, rf_pkg::PSR_SPSR);
		read_regs(4'd0, 4'd13, 4'd14, rf_pkg::PSR_CPSR);
		// illegal mode fields must leave the CPSR as it was
		write_psr(rf_pkg::PSR_CPSR, {6'($urandom_range(0, 63)), 5'b00101});
		read_regs(4'd1, 4'd2, 4'd3, rf_pkg::PSR_CPSR);
		write_psr(rf_pkg::PSR_CPSR, {6'($urandom_range(0, 63)), 5'b11111});
		read_regs(4'd1, 4'd2, 4'd3, rf_pkg::PSR_CPSR);
		// irq takes the autosave, the other SPSRs keep their old values
		for (int m = 1; m <= 5; m++)
		begin
			enter_mode(priv_mode(m % 5));
			read_regs(4'd0, 4'd13, 4'd14, rf_pkg::PSR_SPSR);
		end
		end_test();

		begin_test(5);
		for (int m = 0; m < 5; m++)
		begin
			enter_mode(rf_pkg::MODE_USR);
			enter_mode(priv_mode(m));
			read_regs(4'd13, 4'd14, 4'd0, rf_pkg::PSR_SPSR);
		end
		enter_mode(rf_pkg::MODE_SVC);
		enter_mode(rf_pkg::MODE_IRQ);
		read_regs(4'd13, 4'd14, 4'd0, rf_pkg::PSR_SPSR);
		end_test();

		begin_test(6);
		for (int i = 0; i < RANDOM_CYCLES; i++)
		begin
			wr.load = 1'($urandom_range(0, 1));
			wr.addr = 4'($urandom_range(0, 15));
			wr.data = $urandom();
			psr_wr.load = ($urandom_range(0, 3) == 0);
			psr_wr.sel = rf_pkg::psr_sel_e'(1'($urandom_range(0, 1)));
			psr_wr.flags = {6'($urandom_range(0, 63)), priv_mode(int'($urandom_range(0, 5)))};
			rd_addr = rf_pkg::read_addr_t'(12'($urandom_range(0, 4095)));
			psr_rd_sel = rf_pkg::psr_sel_e'(1'($urandom_range(0, 1)));
			advance();
		end
		wr.load = 1'b0;
		psr_wr.load = 1'b0;
		end_test();

		$display("%0d tests run, %0d checks, %0d errors", tests_run, check_count, error_count);
		if (error_count == 0 && !clk_lost)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verilog/arm_regfile.sv
// ARM7-style banked register file, three read ports and one write port
// all reads are combinational; writes and mode changes land at the edge
`include "rf_defs.svh"

module arm_regfile
(
	input logic sysclk,
	input logic arst_n,
	input rf_pkg::reg_write_t wr,
	input logic [`RF_DATA_W-1:0] pc_write,
	input rf_pkg::psr_write_t psr_wr,
	input rf_pkg::psr_sel_e psr_rd_sel,
	input rf_pkg::read_addr_t rd_addr,
	output rf_pkg::read_data_t rd_data,
	output logic [`RF_DATA_W-1:0] pc_read,
	output logic [`RF_DATA_W-1:0] psr_read
);

	rf_pkg::cpu_mode_e mode;
	rf_pkg::gpr_array_t regs;

	gpr_bank i_gpr
	(
		.sysclk (sysclk),
		.arst_n (arst_n),
		.wr (wr),
		.pc_write (pc_write),
		.mode (mode),
		.regs (regs),
		.pc_read (pc_read)
	);

	psr_bank i_psr
	(
		.sysclk (sysclk),
		.arst_n (arst_n),
		.psr_wr (psr_wr),
		.psr_rd_sel (psr_rd_sel),
		.mode (mode),
		.psr_read (psr_read)
	);

	bank_view i_view
	(
		.regs (regs),
		.mode (mode),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// File: verilog/bank_view.sv
// three combinational read ports over the physical registers
// each address is banked through the current mode
`include "rf_defs.svh"

module bank_view
(
	input rf_pkg::gpr_array_t regs,
	input rf_pkg::cpu_mode_e mode,
	input rf_pkg::read_addr_t rd_addr,
	output rf_pkg::read_data_t rd_data
);

	rf_pkg::phys_idx_t idx_a;
	rf_pkg::phys_idx_t idx_b;
	rf_pkg::phys_idx_t idx_c;

	assign idx_a = rf_pkg::bank_index(mode, rd_addr.a);
	assign idx_b = rf_pkg::bank_index(mode, rd_addr.b);
	assign idx_c = rf_pkg::bank_index(mode, rd_addr.c);

	// indices stay below RF_PHYS_REGS for every legal mode
	assign rd_data.a = regs[idx_a];
	assign rd_data.b = regs[idx_b];
	assign rd_data.c = regs[idx_c];

endmodule

// File: verilog/gpr_bank.sv
// 31 physical general registers with banked write decode
// r15 follows pc_write every cycle unless the write port targets it
`include "rf_defs.svh"

module gpr_bank
(
	input logic sysclk,
	input logic arst_n,
	input rf_pkg::reg_write_t wr,
	input logic [`RF_DATA_W-1:0] pc_write,
	input rf_pkg::cpu_mode_e mode,
	output rf_pkg::gpr_array_t regs,
	output logic [`RF_DATA_W-1:0] pc_read
);

	rf_pkg::phys_idx_t wr_idx;

	// mode is a register output, so a same-cycle CPSR write is not seen here
	assign wr_idx = rf_pkg::bank_index(mode, wr.addr);

	always_ff @(posedge sysclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			regs <= '0;
		end
		else
		begin
			for (int i = 0; i < `RF_PHYS_REGS; i++)
			begin
				if (wr.load && wr_idx == rf_pkg::phys_idx_t'(i))
				begin
					regs[i] <= wr.data;
				end
				else if (i == `RF_PC_ADDR)
				begin
					// pc path loses to a bus write of r15
					regs[i] <= pc_write;
				end
			end
		end
	end

	assign pc_read = regs[`RF_PC_ADDR];

	wr_fields_known: assert property (@(posedge sysclk) disable iff (!arst_n)
		wr.load |-> !$isunknown({wr.addr, wr.data}))
		else $error("register write with unknown address or data");

endmodule

// File: verilog/psr_bank.sv
// CPSR and the five SPSRs, written through the 11-bit flags word
// CPSR writes with an illegal mode field are dropped, so mode stays legal
// user mode has no SPSR; its reads give zero and its writes are ignored
`include "rf_defs.svh"

module psr_bank
(
	input logic sysclk,
	input logic arst_n,
	input rf_pkg::psr_write_t psr_wr,
	input rf_pkg::psr_sel_e psr_rd_sel,
	output rf_pkg::cpu_mode_e mode,
	output logic [`RF_DATA_W-1:0] psr_read
);

	localparam int SPSR_CNT = 5;

	logic [`RF_DATA_W-1:0] cpsr_q;
	logic [SPSR_CNT-1:0][`RF_DATA_W-1:0] spsr_q;
	logic [`RF_DATA_W-1:0] flags_psr;
	rf_pkg::cpu_mode_e new_mode;
	logic [2:0] cur_slot;
	logic [2:0] new_slot;
	logic cpsr_ld;
	logic spsr_ld;
	logic autosave;

	// SPSR slot per privileged mode
	function automatic logic [2:0] spsr_slot(rf_pkg::cpu_mode_e m);
		case (m)
		rf_pkg::MODE_IRQ: spsr_slot = 3'd1;
		rf_pkg::MODE_SVC: spsr_slot = 3'd2;
		rf_pkg::MODE_ABT: spsr_slot = 3'd3;
		rf_pkg::MODE_UND: spsr_slot = 3'd4;
		default: spsr_slot = 3'd0;
		endcase
	endfunction

	assign mode = rf_pkg::cpu_mode_e'(cpsr_q[4:0]);
	assign flags_psr = rf_pkg::pack_flags(psr_wr.flags);
	assign new_mode = rf_pkg::cpu_mode_e'(psr_wr.flags[4:0]);
	assign cur_slot = spsr_slot(mode);
	assign new_slot = spsr_slot(new_mode);

	assign cpsr_ld = psr_wr.load && psr_wr.sel == rf_pkg::PSR_CPSR &&
		rf_pkg::mode_valid(psr_wr.flags[4:0]);
	assign spsr_ld = psr_wr.load && psr_wr.sel == rf_pkg::PSR_SPSR &&
		mode != rf_pkg::MODE_USR;

	// leaving user mode keeps the old CPSR in the new mode's SPSR
	assign autosave = cpsr_ld && mode == rf_pkg::MODE_USR &&
		new_mode != rf_pkg::MODE_USR;

	always_ff @(posedge sysclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cpsr_q <= {{(`RF_DATA_W-5){1'b0}}, rf_pkg::MODE_SVC};
			spsr_q <= '0;
		end
		else
		begin
			if (cpsr_ld)
			begin
				cpsr_q <= flags_psr;
			end
			if (autosave)
			begin
				spsr_q[new_slot] <= cpsr_q;
			end
			else if (spsr_ld)
			begin
				spsr_q[cur_slot] <= flags_psr;
			end
		end
	end

	always_comb
	begin
		if (psr_rd_sel == rf_pkg::PSR_CPSR)
			psr_read = cpsr_q;
		else if (mode == rf_pkg::MODE_USR)
			psr_read = '0;
		else
			psr_read = spsr_q[cur_slot];
	end

	cpsr_mode_legal: assert property (@(posedge sysclk) disable iff (!arst_n)
		rf_pkg::mode_valid(cpsr_q[4:0]))
		else $error("CPSR holds illegal mode field %b", cpsr_q[4:0]);

endmodule

// File: verilog/rf_pkg.sv
// types and helpers shared by the register file blocks
// bank_index is the single place where the banking rule lives
`include "rf_defs.svh"

package rf_pkg;

	// ARM7 mode field encodings
	typedef enum logic [4:0]
	{
		MODE_USR = 5'b10000,
		MODE_FIQ = 5'b10001,
		MODE_IRQ = 5'b10010,
		MODE_SVC = 5'b10011,
		MODE_ABT = 5'b10111,
		MODE_UND = 5'b11011
	} cpu_mode_e;

	typedef enum logic [0:0]
	{
		PSR_CPSR = 1'b0,
		PSR_SPSR = 1'b1
	} psr_sel_e;

	typedef logic [4:0] phys_idx_t;

	typedef logic [`RF_PHYS_REGS-1:0][`RF_DATA_W-1:0] gpr_array_t;

	typedef struct packed
	{
		logic load;
		logic [`RF_ADDR_W-1:0] addr;
		logic [`RF_DATA_W-1:0] data;
	} reg_write_t;

	typedef struct packed
	{
		logic load;
		psr_sel_e sel;
		logic [`RF_FLAGS_W-1:0] flags;
	} psr_write_t;

	typedef struct packed
	{
		logic [`RF_ADDR_W-1:0] a;
		logic [`RF_ADDR_W-1:0] b;
		logic [`RF_ADDR_W-1:0] c;
	} read_addr_t;

	typedef struct packed
	{
		logic [`RF_DATA_W-1:0] a;
		logic [`RF_DATA_W-1:0] b;
		logic [`RF_DATA_W-1:0] c;
	} read_data_t;

	// logical address in a given mode to physical register
	function automatic phys_idx_t bank_index(cpu_mode_e mode, logic [`RF_ADDR_W-1:0] addr);
		phys_idx_t idx;
		phys_idx_t base;
		idx = phys_idx_t'(addr);
		case (mode)
		MODE_IRQ: base = 5'd23;
		MODE_SVC: base = 5'd25;
		MODE_ABT: base = 5'd27;
		MODE_UND: base = 5'd29;
		default: base = 5'd0;
		endcase
		if (mode == MODE_FIQ && addr >= 4'd8 && addr != 4'd15)
			idx = phys_idx_t'(addr) + 5'd8;
		else if (base != 5'd0 && (addr == 4'd13 || addr == 4'd14))
			idx = base + phys_idx_t'(addr - 4'd13);
		return idx;
	endfunction

	function automatic logic mode_valid(logic [4:0] m);
		return m inside {MODE_USR, MODE_FIQ, MODE_IRQ, MODE_SVC, MODE_ABT, MODE_UND};
	endfunction

	// flags go to 31..28, 7..6 and 4..0; the rest reads as zero
	function automatic logic [`RF_DATA_W-1:0] pack_flags(logic [`RF_FLAGS_W-1:0] f);
		return {f[10:7], 20'b0, f[6:5], 1'b0, f[4:0]};
	endfunction

endpackage
